// ==== hw/event_control_top.sv ====
`timescale 1ns/1ps

module event_control_top (
    input  logic                                aclk,
    input  logic                                arst_n_i,

    input  event_ctrl_pkg::wb_req_t             wb_req_i,
    output event_ctrl_pkg::wb_rsp_t             wb_rsp_o,

    input  event_ctrl_pkg::track_err_t          track_err_i,
    input  logic                                event_open_i,

    input  logic [event_ctrl_pkg::NUM_LINKS-1:0] link_tvalid_i,
    input  logic                                eth_tx_qword_i,
    input  logic                                eth_tx_event_i,

    output logic                                event_reset_o,
    output event_ctrl_pkg::tio_mask_t           tio_mask_o,
    output event_ctrl_pkg::runcfg_t             runcfg_o
);

    import event_ctrl_pkg::*;

    logic   event_reset;
    count_t link_count [NUM_LINKS];
    count_t tx_count [NUM_TX_COUNTS];

    // Quadword strobe in slot 0, event strobe in slot 1.
    logic [NUM_TX_COUNTS-1:0] tx_strobe;
    assign tx_strobe = {eth_tx_event_i, eth_tx_qword_i};

    event_register_core u_core (
        .aclk          (aclk),
        .arst_n_i      (arst_n_i),
        .wb_req_i      (wb_req_i),
        .wb_rsp_o      (wb_rsp_o),
        .track_err_i   (track_err_i),
        .event_open_i  (event_open_i),
        .link_count_i  (link_count),
        .tx_count_i    (tx_count),
        .event_reset_o (event_reset),
        .tio_mask_o    (tio_mask_o),
        .runcfg_o      (runcfg_o)
    );

    // Link word counters.
    event_stat_counter #(
        .NUM_COUNTS (NUM_LINKS)
    ) u_link_stats (
        .aclk     (aclk),
        .arst_n_i (arst_n_i),
        .clear_i  (event_reset),
        .strobe_i (link_tvalid_i),
        .count_o  (link_count)
    );

    // Ethernet transmit counters.
    event_stat_counter #(
        .NUM_COUNTS (NUM_TX_COUNTS)
    ) u_tx_stats (
        .aclk     (aclk),
        .arst_n_i (arst_n_i),
        .clear_i  (event_reset),
        .strobe_i (tx_strobe),
        .count_o  (tx_count)
    );

    assign event_reset_o = event_reset;

endmodule

// ==== hw/event_ctrl_pkg.sv ====
package event_ctrl_pkg;

    // Bus and field widths.
    localparam int ADDR_W   = 4;
    localparam int DATA_W   = 32;
    localparam int SEL_W    = DATA_W / 8;
    localparam int COUNT_W  = 32;
    localparam int TIO_W    = 4;
    localparam int RUNCFG_W = 12;
    localparam int TRKERR_W = 4;
    localparam int NUM_REGS = 2 ** ADDR_W;

    localparam int NUM_LINKS     = 4;
    localparam int NUM_TX_COUNTS = 2;
    localparam int TX_QWORD_IDX  = 0;
    localparam int TX_EVENT_IDX  = 1;

    typedef logic [ADDR_W-1:0]   reg_addr_t;
    typedef logic [DATA_W-1:0]   reg_data_t;
    typedef logic [COUNT_W-1:0]  count_t;
    typedef logic [TIO_W-1:0]    tio_mask_t;
    typedef logic [RUNCFG_W-1:0] runcfg_t;
    typedef logic [TRKERR_W-1:0] track_err_t;

    // Register map, in word indices.
    localparam reg_addr_t ADDR_GLOBAL          = 4'd0;
    localparam reg_addr_t ADDR_GLOBAL_RD       = 4'd1;
    localparam reg_addr_t ADDR_GLOBAL_ALIAS_LO = 4'd2;
    localparam reg_addr_t ADDR_GLOBAL_ALIAS_HI = 4'd3;
    localparam reg_addr_t ADDR_LINK_BASE       = 4'd4;
    localparam reg_addr_t ADDR_TX_QWORDS       = 4'd8;
    localparam reg_addr_t ADDR_TX_EVENTS       = 4'd9;
    localparam reg_addr_t ADDR_MIRROR_BASE     = 4'd10;

    // Global word layout.
    localparam int GLB_FORCE_BIT   = 0;  // Read/write.
    localparam int GLB_EVRST_BIT   = 1;  // Read-only.
    localparam int GLB_MASK_LSB    = 8;
    localparam int GLB_TRKERR_LSB  = 12; // Read-only.
    localparam int GLB_RUNCFG_LSB  = 16;
    localparam int RUNCFG_LO_W     = 8;  // Byte lane 2 part of run configuration.

    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        reg_addr_t        adr;
        logic [SEL_W-1:0] sel;
        reg_data_t        dat;
    } wb_req_t;

    typedef struct packed {
        logic      ack;
        reg_data_t dat;
    } wb_rsp_t;

endpackage

// ==== hw/event_register_core.sv ====
`timescale 1ns/1ps

module event_register_core (
    input  logic                        aclk,
    input  logic                        arst_n_i,

    input  event_ctrl_pkg::wb_req_t     wb_req_i,
    output event_ctrl_pkg::wb_rsp_t     wb_rsp_o,

    input  event_ctrl_pkg::track_err_t  track_err_i,
    input  logic                        event_open_i,

    input  event_ctrl_pkg::count_t      link_count_i [event_ctrl_pkg::NUM_LINKS],
    input  event_ctrl_pkg::count_t      tx_count_i [event_ctrl_pkg::NUM_TX_COUNTS],

    output logic                        event_reset_o,
    output event_ctrl_pkg::tio_mask_t   tio_mask_o,
    output event_ctrl_pkg::runcfg_t     runcfg_o
);

    import event_ctrl_pkg::*;

    logic       req;
    logic       ack_q;
    logic       wr_glob;
    reg_data_t  rd_dat_q;

    logic       force_q;
    tio_mask_t  mask_q;
    runcfg_t    runcfg_q;
    track_err_t trk_err_q;
    logic       evrst_q;

    reg_data_t  glob_word;
    reg_data_t  base_map [ADDR_MIRROR_BASE];
    reg_data_t  rd_map [NUM_REGS];

    // Bus request and write strobe.
    assign req = wb_req_i.cyc && wb_req_i.stb;

    // Writes land in the ack cycle, only at the global index.
    assign wr_glob = req && ack_q && wb_req_i.we && (wb_req_i.adr == ADDR_GLOBAL);

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req; // Held while the master holds its request.
        end
    end

    // Read data sampled on the first request cycle.
    always_ff @(posedge aclk) begin
        if (req && !wb_req_i.we && !ack_q) begin
            rd_dat_q <= rd_map[wb_req_i.adr];
        end
    end

    // Global control register, one field per byte lane.
    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            force_q  <= 1'b0;
            mask_q   <= '0;
            runcfg_q <= '0;
        end else if (wr_glob) begin
            if (wb_req_i.sel[0]) begin
                force_q <= wb_req_i.dat[GLB_FORCE_BIT];
            end
            if (wb_req_i.sel[1]) begin
                mask_q <= wb_req_i.dat[GLB_MASK_LSB +: TIO_W];
            end
            if (wb_req_i.sel[2]) begin
                runcfg_q[0 +: RUNCFG_LO_W] <= wb_req_i.dat[GLB_RUNCFG_LSB +: RUNCFG_LO_W];
            end
            if (wb_req_i.sel[3]) begin
                runcfg_q[RUNCFG_LO_W +: RUNCFG_W-RUNCFG_LO_W] <=
                    wb_req_i.dat[GLB_RUNCFG_LSB+RUNCFG_LO_W +: RUNCFG_W-RUNCFG_LO_W];
            end
        end
    end

    // Event reset while forced or while no event is open.
    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            evrst_q <= 1'b0;
        end else begin
            evrst_q <= force_q || !event_open_i;
        end
    end

    always_ff @(posedge aclk) begin
        trk_err_q <= track_err_i;
    end

    // Global word as seen on readback.
    always_comb begin
        glob_word = '0;
        glob_word[GLB_FORCE_BIT]                  = force_q;
        glob_word[GLB_EVRST_BIT]                  = evrst_q;
        glob_word[GLB_MASK_LSB +: TIO_W]          = mask_q;
        glob_word[GLB_TRKERR_LSB +: TRKERR_W]     = trk_err_q;
        glob_word[GLB_RUNCFG_LSB +: RUNCFG_W]     = runcfg_q;
    end

    // Lower part of the map holds the real registers.
    always_comb begin
        base_map = '{default: '0};
        base_map[ADDR_GLOBAL]          = glob_word;
        base_map[ADDR_GLOBAL_RD]       = glob_word;
        base_map[ADDR_GLOBAL_ALIAS_LO] = glob_word;
        base_map[ADDR_GLOBAL_ALIAS_HI] = glob_word;
        for (int i = 0; i < NUM_LINKS; i++) begin
            base_map[int'(ADDR_LINK_BASE) + i] = link_count_i[i];
        end
        base_map[ADDR_TX_QWORDS] = tx_count_i[TX_QWORD_IDX];
        base_map[ADDR_TX_EVENTS] = tx_count_i[TX_EVENT_IDX];
    end

    // Upper indices repeat the aliases and link counters.
    always_comb begin
        for (int i = 0; i < int'(ADDR_MIRROR_BASE); i++) begin
            rd_map[i] = base_map[i];
        end
        for (int i = int'(ADDR_MIRROR_BASE); i < NUM_REGS; i++) begin
            rd_map[i] = base_map[i - int'(ADDR_MIRROR_BASE) + int'(ADDR_GLOBAL_ALIAS_LO)];
        end
    end

    assign wb_rsp_o.ack = ack_q && req;
    assign wb_rsp_o.dat = rd_dat_q;

    assign event_reset_o = evrst_q;
    assign tio_mask_o    = mask_q;
    assign runcfg_o      = runcfg_q;

endmodule

// ==== hw/event_stat_counter.sv ====
`timescale 1ns/1ps

module event_stat_counter #(
    parameter int NUM_COUNTS = event_ctrl_pkg::NUM_LINKS
) (
    input  logic                    aclk,
    input  logic                    arst_n_i,
    input  logic                    clear_i,
    input  logic [NUM_COUNTS-1:0]   strobe_i,
    output event_ctrl_pkg::count_t  count_o [NUM_COUNTS]
);

    import event_ctrl_pkg::*;

    count_t cnt_q [NUM_COUNTS];

    // One free-running counter per strobe.
    for (genvar i = 0; i < NUM_COUNTS; i++) begin : g_cnt

        count_t cnt_d;

        // Clear has priority over a strobe in the same cycle.
        always_comb begin
            cnt_d = cnt_q[i];
            if (clear_i) begin
                cnt_d = '0;
            end else if (strobe_i[i]) begin
                cnt_d = cnt_q[i] + count_t'(1); // Wraps modulo 2^32.
            end
        end

        always_ff @(posedge aclk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                cnt_q[i] <= '0;
            end else begin
                cnt_q[i] <= cnt_d;
            end
        end

        assign count_o[i] = cnt_q[i];

    end

endmodule

// ==== project.f ====
hw/event_ctrl_pkg.sv
hw/event_stat_counter.sv
hw/event_register_core.sv
hw/event_control_top.sv
verification/tb_clk_gen.sv
verification/event_control_sva.sv
verification/event_control_tb.sv

// ==== verification/event_control_sva.sv ====
`timescale 1ns/1ps

module event_control_sva (
    input  logic                     aclk,
    input  logic                     arst_n_i,
    input  event_ctrl_pkg::wb_req_t  wb_req_i,
    input  event_ctrl_pkg::wb_rsp_t  wb_rsp_i,
    input  logic                     force_i,
    input  logic                     event_open_i,
    input  logic                     event_reset_i,
    input  event_ctrl_pkg::count_t   link_count_i [event_ctrl_pkg::NUM_LINKS],
    input  event_ctrl_pkg::count_t   tx_count_i [event_ctrl_pkg::NUM_TX_COUNTS]
);

    import event_ctrl_pkg::*;

    int unsigned errors = 0;
    logic        req;
    logic        counts_zero;

    assign req = wb_req_i.cyc && wb_req_i.stb;

    always_comb begin
        counts_zero = 1'b1;
        for (int i = 0; i < NUM_LINKS; i++) begin
            counts_zero &= (link_count_i[i] == '0);
        end
        for (int i = 0; i < NUM_TX_COUNTS; i++) begin
            counts_zero &= (tx_count_i[i] == '0);
        end
    end

    // Ack only in a request that was already present one cycle earlier.
    ack_in_request: assert property (@(posedge aclk) disable iff (!arst_n_i)
        wb_rsp_i.ack |-> req && $past(req))
        else begin $error("ack outside of a held request"); errors++; end

    // No ack in the first request cycle, ack in the next.
    ack_not_first: assert property (@(posedge aclk) disable iff (!arst_n_i)
        $rose(req) |-> !wb_rsp_i.ack)
        else begin $error("ack in the first request cycle"); errors++; end

    ack_one_later: assert property (@(posedge aclk) disable iff (!arst_n_i)
        req && !wb_rsp_i.ack |=> wb_rsp_i.ack)
        else begin $error("ack missing one cycle after the request"); errors++; end

    event_reset_follows: assert property (@(posedge aclk) disable iff (!arst_n_i)
        $past(arst_n_i) |-> event_reset_i == $past(force_i || !event_open_i))
        else begin $error("event reset does not follow force or open"); errors++; end

    counters_cleared: assert property (@(posedge aclk) disable iff (!arst_n_i)
        event_reset_i |=> counts_zero)
        else begin $error("counter not zero after event reset"); errors++; end

endmodule

// ==== verification/event_control_tb.sv ====
`timescale 1ns/1ps

module event_control_tb;

    import event_ctrl_pkg::*;

    localparam int ACK_TIMEOUT  = 20;
    localparam int WAIT_TIMEOUT = 50;
    localparam int NUM_TESTS    = 6;
    localparam logic [3:0] SEL_LIST [7] = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h6, 4'hF, 4'h0};

    logic                 aclk;
    logic                 arst_n;
    wb_req_t              wb_req;
    wb_rsp_t              wb_rsp;
    track_err_t           track_err;
    logic                 event_open;
    logic [NUM_LINKS-1:0] link_tvalid;
    logic                 eth_tx_qword;
    logic                 eth_tx_event;
    logic                 event_reset;
    tio_mask_t            tio_mask;
    runcfg_t              runcfg;

    // Expected state of the register block.
    logic        exp_force;
    tio_mask_t   exp_mask;
    runcfg_t     exp_runcfg;
    track_err_t  exp_trk;
    count_t      exp_link [NUM_LINKS];
    count_t      exp_tx [NUM_TX_COUNTS];

    logic [31:0] lcg_state = 32'd15879;
    int unsigned checks;
    int unsigned errors;
    int unsigned errors_at_start;
    logic [31:0] r;

    tb_clk_gen u_clk (
        .aclk     (aclk),
        .arst_n_o (arst_n)
    );

    event_control_top dut (
        .aclk           (aclk),
        .arst_n_i       (arst_n),
        .wb_req_i       (wb_req),
        .wb_rsp_o       (wb_rsp),
        .track_err_i    (track_err),
        .event_open_i   (event_open),
        .link_tvalid_i  (link_tvalid),
        .eth_tx_qword_i (eth_tx_qword),
        .eth_tx_event_i (eth_tx_event),
        .event_reset_o  (event_reset),
        .tio_mask_o     (tio_mask),
        .runcfg_o       (runcfg)
    );

    bind event_register_core event_control_sva u_sva (
        .aclk          (aclk),
        .arst_n_i      (arst_n_i),
        .wb_req_i      (wb_req_i),
        .wb_rsp_i      (wb_rsp_o),
        .force_i       (force_q),
        .event_open_i  (event_open_i),
        .event_reset_i (event_reset_o),
        .link_count_i  (link_count_i),
        .tx_count_i    (tx_count_i)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned total_errors();
        return errors + dut.u_core.u_sva.errors;
    endfunction

    function automatic reg_data_t global_word();
        reg_data_t w;
        w        = '0;
        w[0]     = exp_force;
        w[1]     = exp_force || !event_open;
        w[11:8]  = exp_mask;
        w[15:12] = exp_trk;
        w[27:16] = exp_runcfg;
        return w;
    endfunction

    // Aliases at 1 to 3, mirrors of 2 to 7 at 10 to 15.
    function automatic reg_data_t expected_read(input int idx);
        int k;
        k = (idx >= 10) ? idx - 8 : idx;
        if (k <= 3) begin
            return global_word();
        end
        if (k <= 7) begin
            return exp_link[k-4];
        end
        return exp_tx[k-8];
    endfunction

    function automatic void apply_write(input reg_data_t dat, input logic [3:0] sel);
        if (sel[0]) exp_force = dat[0];
        if (sel[1]) exp_mask = dat[11:8];
        if (sel[2]) exp_runcfg[7:0] = dat[23:16];
        if (sel[3]) exp_runcfg[11:8] = dat[27:24];
    endfunction

    function automatic void clear_counts();
        for (int i = 0; i < NUM_LINKS; i++) begin
            exp_link[i] = '0;
        end
        for (int i = 0; i < NUM_TX_COUNTS; i++) begin
            exp_tx[i] = '0;
        end
    endfunction

    function automatic void check_value(input string name, input reg_data_t exp,
                                        input reg_data_t act);
        checks++;
        assert (act === exp) else begin
            $display("FAILED %s: expected 0x%08h, got 0x%08h", name, exp, act);
            errors++;
        end
    endfunction

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (arst_n !== 1'b1 && waited < WAIT_TIMEOUT) begin
            @(negedge aclk);
            waited++;
        end
        assert (arst_n === 1'b1) else begin
            $display("Timeout: reset was never released");
            errors++;
        end
    endtask

    task automatic wait_event_reset(input logic level);
        int waited;
        waited = 0;
        @(negedge aclk);
        while (event_reset !== level && waited < WAIT_TIMEOUT) begin
            @(negedge aclk);
            waited++;
        end
        assert (event_reset === level) else begin
            $display("Timeout: event reset did not reach %0d", level);
            errors++;
        end
    endtask

    // One bus cycle; the request is held until ack, then stb drops.
    task automatic bus_access(input logic we, input reg_addr_t adr, input reg_data_t wdat,
                              input logic [3:0] sel, output reg_data_t rdat);
        int waited;
        @(posedge aclk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: wdat};
        waited = 0;
        @(negedge aclk);
        while (!wb_rsp.ack && waited < ACK_TIMEOUT) begin
            @(negedge aclk);
            waited++;
        end
        assert (wb_rsp.ack) else begin
            $display("Timeout: no ack within %0d cycles at index %0d", ACK_TIMEOUT, adr);
            errors++;
        end
        rdat = wb_rsp.dat;
        @(posedge aclk);
        wb_req <= '0;
        @(negedge aclk);
    endtask

    task automatic write_reg(input reg_addr_t adr, input reg_data_t dat, input logic [3:0] sel);
        reg_data_t unused;
        bus_access(1'b1, adr, dat, sel, unused);
    endtask

    task automatic read_reg(input reg_addr_t adr, output reg_data_t dat);
        bus_access(1'b0, adr, '0, 4'hF, dat);
    endtask

    task automatic drive_strobes(input int cycles, input bit counted);
        logic [31:0] v;
        for (int n = 0; n < cycles; n++) begin
            @(posedge aclk);
            v = next_rand();
            link_tvalid  <= v[27:24];
            eth_tx_qword <= v[28];
            eth_tx_event <= v[29];
            if (counted) begin
                for (int i = 0; i < NUM_LINKS; i++) begin
                    exp_link[i] = exp_link[i] + count_t'(v[24+i]);
                end
                exp_tx[0] = exp_tx[0] + count_t'(v[28]);
                exp_tx[1] = exp_tx[1] + count_t'(v[29]);
            end
        end
        @(posedge aclk);
        link_tvalid  <= '0;
        eth_tx_qword <= 1'b0;
        eth_tx_event <= 1'b0;
    endtask

    task automatic check_readback(input int first, input int last);
        reg_data_t d;
        for (int idx = first; idx <= last; idx++) begin
            read_reg(reg_addr_t'(idx), d);
            check_value($sformatf("wb_rsp_o.dat[%0d]", idx), expected_read(idx), d);
        end
    endtask

    task automatic report_test(input string name);
        int unsigned n;
        n = total_errors() - errors_at_start;
        if (n == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, n);
        end
        errors_at_start = total_errors();
    endtask

    initial begin
        wb_req       = '0;
        track_err    = '0;
        event_open   = 1'b0;
        link_tvalid  = '0;
        eth_tx_qword = 1'b0;
        eth_tx_event = 1'b0;
        exp_force    = 1'b0;
        exp_mask     = '0;
        exp_runcfg   = '0;
        exp_trk      = '0;
        checks          = 0;
        errors          = 0;
        errors_at_start = 0;
        clear_counts();

        wait_reset_release();
        repeat (2) @(negedge aclk);

        check_value("event_reset_o", 32'd1, 32'(event_reset)); // Event closed after reset.
        for (int s = 0; s < 7; s++) begin
            r = next_rand();
            write_reg(ADDR_GLOBAL, r, SEL_LIST[s]);
            apply_write(r, SEL_LIST[s]);
            check_value("tio_mask_o", 32'(exp_mask), 32'(tio_mask));
            check_value("runcfg_o", 32'(exp_runcfg), 32'(runcfg));
            check_readback(0, 0);
        end
        report_test("global write with byte enables");

        check_readback(1, 15);
        for (int idx = 1; idx < 16; idx += 5) begin
            write_reg(reg_addr_t'(idx), next_rand(), 4'hF); // Ignored by the core.
        end
        check_value("tio_mask_o", 32'(exp_mask), 32'(tio_mask));
        check_value("runcfg_o", 32'(exp_runcfg), 32'(runcfg));
        check_readback(0, 3);
        report_test("address aliasing");

        write_reg(ADDR_GLOBAL, 32'h0, 4'h1);
        apply_write(32'h0, 4'h1);
        @(posedge aclk);
        event_open <= 1'b1;
        wait_event_reset(1'b0);
        clear_counts();
        drive_strobes(200, 1'b1);
        check_readback(4, 7);
        check_readback(12, 15);
        report_test("link counting");

        drive_strobes(150, 1'b1);
        check_readback(8, 9);
        report_test("transmit counting");

        write_reg(ADDR_GLOBAL, 32'h1, 4'h1);
        apply_write(32'h1, 4'h1);
        wait_event_reset(1'b1);
        clear_counts();
        drive_strobes(20, 1'b0); // Reset wins over counting.
        check_readback(0, 0);
        check_readback(4, 9);
        write_reg(ADDR_GLOBAL, 32'h0, 4'h1);
        apply_write(32'h0, 4'h1);
        wait_event_reset(1'b0);
        drive_strobes(50, 1'b1);
        check_readback(4, 9);
        @(posedge aclk);
        event_open <= 1'b0;
        wait_event_reset(1'b1);
        clear_counts();
        check_readback(0, 0);
        check_readback(4, 9);
        @(posedge aclk);
        event_open <= 1'b1;
        wait_event_reset(1'b0);
        drive_strobes(40, 1'b1);
        check_readback(4, 9);
        report_test("event reset");

        for (int n = 0; n < 3; n++) begin
            r = next_rand();
            @(posedge aclk);
            track_err <= r[19:16];
            exp_trk = r[19:16];
            check_readback(0, 0);
            check_readback(2, 2);
        end
        report_test("track errors");

        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, total_errors());
        if (total_errors() == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS  = 20.0,
    parameter int  RST_CYCLES = 8
) (
    output logic aclk,
    output logic arst_n_o
);

    initial begin
        aclk = 1'b0;
        forever #(PERIOD_NS / 2.0) aclk = ~aclk;
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge aclk);
        arst_n_o <= 1'b1; // Released on a rising edge.
    end

endmodule
